/* src/logMulPkg.sv */
// Log-domain multiplier shared constants
// Operand, log and product widths plus the
// table geometry used by the converters and antilog stage

`default_nettype none

package logMulPkg;

  ////////////////////////////////////////
  // Operand side
  ////////////////////////////////////////

  // Unsigned input operand width
  localparam int operandWidth = 16;

  // Entries in each one-octave table
  localparam int tableDepth = 64;

  // Log value split into integer and fraction
  localparam int logIntWidth  = 4;
  localparam int logFracWidth = $clog2(tableDepth);
  localparam int logWidth     = logIntWidth + logFracWidth;

  ////////////////////////////////////////
  // Antilog side
  ////////////////////////////////////////

  // Sum of two logs, 6.6 fixed point
  localparam int logSumWidth = 12;

  // Table entry is the 23-bit fraction of 1.f
  localparam int mantWidth = 23;

  // Integer product taken from the shifter
  localparam int productWidth = 32;

  // Fraction bits kept below the product
  localparam int shiftFracBits = 8;

endpackage

`default_nettype wire

/* src/logOperandIf.sv */
// Operand log bundle
// Carries one operand's base-2 log and zero flag from
// a converter to the antilog stage

`default_nettype none

interface logOperandIf;
  import logMulPkg::*;

  // One strobe per item
  logic                    valid;
  // Operand was zero, log fields meaningless
  logic                    isZero;
  logic [logIntWidth-1:0]  logInt;
  logic [logFracWidth-1:0] logFrac;

  // Converter side
  modport src (output valid, isZero, logInt, logFrac);

  // Antilog side
  modport dst (input valid, isZero, logInt, logFrac);

endinterface

`default_nettype wire

/* src/log2Converter.sv */
// Base-2 log converter
// Leading-one detection gives the integer part, the six bits below
// the leading one index a 64-entry table of log2(1+m/64) fractions.
// Output registered, one cycle from inValid to logOut.valid

`default_nettype none

module log2Converter (
  input  logic                              clk,
  input  logic                              arstN,
  input  logic                              inValid,
  input  logic [logMulPkg::operandWidth-1:0] operand,
  logOperandIf.src                          logOut
);
  import logMulPkg::*;

  logic [logIntWidth-1:0]  leadPos;
  logic [operandWidth-1:0] normOp;
  logic [logFracWidth-1:0] mant;
  logic [logFracWidth-1:0] fracD;
  logic                    zeroD;

  ////////////////////////////////////////
  // Leading one and mantissa
  ////////////////////////////////////////

  // Highest set bit wins
  always_comb begin
    leadPos = '0;
    for (int i = 0; i < operandWidth; i++) begin
      if (operand[i]) begin
        leadPos = logIntWidth'(i);
      end
    end
  end

  assign zeroD = (operand == '0);

  // Normalize so the leading one sits at the MSB
  // zeros shift in below when fewer than six bits exist
  assign normOp = operand << (logIntWidth'(operandWidth - 1) - leadPos);
  assign mant   = normOp[operandWidth-2 -: logFracWidth];

  ////////////////////////////////////////
  // Log fraction table
  ////////////////////////////////////////

  // round(log2(1 + m/64) * 64)
  always_comb begin
    case (mant)
      6'd0:  fracD = 6'd0;
      6'd1:  fracD = 6'd1;
      6'd2:  fracD = 6'd3;
      6'd3:  fracD = 6'd4;
      6'd4:  fracD = 6'd6;
      6'd5:  fracD = 6'd7;
      6'd6:  fracD = 6'd8;
      6'd7:  fracD = 6'd10;
      6'd8:  fracD = 6'd11;
      6'd9:  fracD = 6'd12;
      6'd10: fracD = 6'd13;
      6'd11: fracD = 6'd15;
      6'd12: fracD = 6'd16;
      6'd13: fracD = 6'd17;
      6'd14: fracD = 6'd18;
      6'd15: fracD = 6'd19;
      6'd16: fracD = 6'd21;
      6'd17: fracD = 6'd22;
      6'd18: fracD = 6'd23;
      6'd19: fracD = 6'd24;
      6'd20: fracD = 6'd25;
      6'd21: fracD = 6'd26;
      6'd22: fracD = 6'd27;
      6'd23: fracD = 6'd28;
      6'd24: fracD = 6'd29;
      6'd25: fracD = 6'd30;
      6'd26: fracD = 6'd31;
      6'd27: fracD = 6'd32;
      6'd28: fracD = 6'd34;
      6'd29: fracD = 6'd35;
      6'd30: fracD = 6'd35;
      6'd31: fracD = 6'd36;
      6'd32: fracD = 6'd37;
      6'd33: fracD = 6'd38;
      6'd34: fracD = 6'd39;
      6'd35: fracD = 6'd40;
      6'd36: fracD = 6'd41;
      6'd37: fracD = 6'd42;
      6'd38: fracD = 6'd43;
      6'd39: fracD = 6'd44;
      6'd40: fracD = 6'd45;
      6'd41: fracD = 6'd46;
      6'd42: fracD = 6'd47;
      6'd43: fracD = 6'd47;
      6'd44: fracD = 6'd48;
      6'd45: fracD = 6'd49;
      6'd46: fracD = 6'd50;
      6'd47: fracD = 6'd51;
      6'd48: fracD = 6'd52;
      6'd49: fracD = 6'd52;
      6'd50: fracD = 6'd53;
      6'd51: fracD = 6'd54;
      6'd52: fracD = 6'd55;
      6'd53: fracD = 6'd56;
      6'd54: fracD = 6'd56;
      6'd55: fracD = 6'd57;
      6'd56: fracD = 6'd58;
      6'd57: fracD = 6'd59;
      6'd58: fracD = 6'd60;
      6'd59: fracD = 6'd60;
      6'd60: fracD = 6'd61;
      6'd61: fracD = 6'd62;
      6'd62: fracD = 6'd63;
      default: fracD = 6'd63;
    endcase
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      logOut.valid <= 1'b0;
    end else begin
      logOut.valid <= inValid;
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    logOut.isZero  <= zeroD;
    logOut.logInt  <= leadPos;
    logOut.logFrac <= fracD;
  end

endmodule

`default_nettype wire

/* src/antilogUnit.sv */
// Fast base-2 antilog of the summed operand logs
// Stage 1 adds the logs, registers shift count, octave table entry
// and merged zero flag. Stage 2 barrel-shifts 1.f and registers
// the 32.8 result. Two cycles from logA.valid to outValid

`default_nettype none

module antilogUnit (
  input  logic                               clk,
  input  logic                               arstN,
  logOperandIf.dst                           logA,
  logOperandIf.dst                           logB,
  output logic                               outValid,
  output logic [logMulPkg::productWidth-1:0] product
);
  import logMulPkg::*;

  logic [logWidth-1:0]                 logAVal;
  logic [logWidth-1:0]                 logBVal;
  logic [logSumWidth-1:0]              logSum;
  logic [mantWidth-1:0]                lutD;

  // Stage 1
  logic                                validQ1;
  logic                                zeroQ1;
  logic [logSumWidth-logFracWidth-1:0] shiftQ1;
  logic [mantWidth-1:0]                lutQ1;

  // Stage 2
  logic [productWidth+mantWidth-1:0]   shifted;
  logic [productWidth+shiftFracBits-1:0] fixedD;
  logic [productWidth+shiftFracBits-1:0] fixedQ2;

  ////////////////////////////////////////
  // Log sum, 6.6 format
  ////////////////////////////////////////

  assign logAVal = {logA.logInt, logA.logFrac};
  assign logBVal = {logB.logInt, logB.logFrac};
  assign logSum  = logSumWidth'(logAVal) + logSumWidth'(logBVal);

  // One octave of (2^(f/64) - 1) * 2^23
  always_comb begin
    case (logSum[logFracWidth-1:0])
      6'd0:  lutD = 23'd0;
      6'd1:  lutD = 23'd91346;
      6'd2:  lutD = 23'd183687;
      6'd3:  lutD = 23'd277033;
      6'd4:  lutD = 23'd371395;
      6'd5:  lutD = 23'd466786;
      6'd6:  lutD = 23'd563215;
      6'd7:  lutD = 23'd660693;
      6'd8:  lutD = 23'd759234;
      6'd9:  lutD = 23'd858847;
      6'd10: lutD = 23'd959546;
      6'd11: lutD = 23'd1061340;
      6'd12: lutD = 23'd1164243;
      6'd13: lutD = 23'd1268267;
      6'd14: lutD = 23'd1373424;
      6'd15: lutD = 23'd1479725;
      6'd16: lutD = 23'd1587184;
      6'd17: lutD = 23'd1695814;
      6'd18: lutD = 23'd1805626;
      6'd19: lutD = 23'd1916634;
      6'd20: lutD = 23'd2028850;
      6'd21: lutD = 23'd2142289;
      6'd22: lutD = 23'd2256963;
      6'd23: lutD = 23'd2372886;
      6'd24: lutD = 23'd2490071;
      6'd25: lutD = 23'd2608532;
      6'd26: lutD = 23'd2728283;
      6'd27: lutD = 23'd2849338;
      6'd28: lutD = 23'd2971711;
      6'd29: lutD = 23'd3095417;
      6'd30: lutD = 23'd3220470;
      6'd31: lutD = 23'd3346884;
      6'd32: lutD = 23'd3474675;
      6'd33: lutD = 23'd3603858;
      6'd34: lutD = 23'd3734447;
      6'd35: lutD = 23'd3866459;
      6'd36: lutD = 23'd3999908;
      6'd37: lutD = 23'd4134810;
      6'd38: lutD = 23'd4271181;
      6'd39: lutD = 23'd4409037;
      6'd40: lutD = 23'd4548394;
      6'd41: lutD = 23'd4689269;
      6'd42: lutD = 23'd4831678;
      6'd43: lutD = 23'd4975637;
      6'd44: lutD = 23'd5121164;
      6'd45: lutD = 23'd5268276;
      6'd46: lutD = 23'd5416990;
      6'd47: lutD = 23'd5567323;
      6'd48: lutD = 23'd5719293;
      6'd49: lutD = 23'd5872918;
      6'd50: lutD = 23'd6028216;
      6'd51: lutD = 23'd6185205;
      6'd52: lutD = 23'd6343903;
      6'd53: lutD = 23'd6504329;
      6'd54: lutD = 23'd6666503;
      6'd55: lutD = 23'd6830442;
      6'd56: lutD = 23'd6996167;
      6'd57: lutD = 23'd7163696;
      6'd58: lutD = 23'd7333050;
      6'd59: lutD = 23'd7504247;
      6'd60: lutD = 23'd7677309;
      6'd61: lutD = 23'd7852255;
      6'd62: lutD = 23'd8029107;
      default: lutD = 23'd8207884;
    endcase
  end

  ////////////////////////////////////////
  // Stage 1 registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validQ1 <= 1'b0;
    end else begin
      validQ1 <= logA.valid & logB.valid;
    end
  end

  // Integer part of the sum becomes the shift count
  always_ff @(posedge clk) begin
    shiftQ1 <= logSum[logSumWidth-1:logFracWidth];
    lutQ1   <= lutD;
    zeroQ1  <= logA.isZero | logB.isZero;
  end

  ////////////////////////////////////////
  // Stage 2, barrel shifter
  ////////////////////////////////////////

  // Implicit one restored above the table fraction
  // bits beyond the 32-bit product are dropped
  assign shifted = (productWidth + mantWidth)'({1'b1, lutQ1}) << shiftQ1;

  // Keep 32.8 window, zero operand overrides
  assign fixedD = zeroQ1 ? '0 : shifted[productWidth+mantWidth-1 -: productWidth+shiftFracBits];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= validQ1;
    end
  end

  always_ff @(posedge clk) begin
    fixedQ2 <= fixedD;
  end

  // Integer part only, fraction truncated
  assign product = fixedQ2[productWidth+shiftFracBits-1:shiftFracBits];

endmodule

`default_nettype wire

/* src/logMulTop.sv */
// Log-domain multiplier top
// Two operand log converters feed one antilog unit.
// Fully pipelined, one pair per cycle, 3 cycles inValid to outValid

`default_nettype none

module logMulTop (
  input  logic                               clk,
  input  logic                               arstN,
  input  logic                               inValid,
  input  logic [logMulPkg::operandWidth-1:0] opA,
  input  logic [logMulPkg::operandWidth-1:0] opB,
  output logic                               outValid,
  output logic [logMulPkg::productWidth-1:0] product
);

  // One log bundle per operand
  logOperandIf logAIf ();
  logOperandIf logBIf ();

  ////////////////////////////////////////
  // Operand converters
  ////////////////////////////////////////

  log2Converter log2ConverterA (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .operand (opA),
    .logOut  (logAIf.src)
  );

  log2Converter log2ConverterB (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .operand (opB),
    .logOut  (logBIf.src)
  );

  // Log sum and antilog
  antilogUnit antilogUnit (
    .clk      (clk),
    .arstN    (arstN),
    .logA     (logAIf.dst),
    .logB     (logBIf.dst),
    .outValid (outValid),
    .product  (product)
  );

endmodule

`default_nettype wire

/* testbench/logMul_sva.sv */
// Log multiplier protocol assertions
// Fixed three-cycle valid latency and zero products,
// bound onto the top level

`default_nettype none

module logMulSva (
  input logic                               clk,
  input logic                               arstN,
  input logic                               inValid,
  input logic [logMulPkg::operandWidth-1:0] opA,
  input logic [logMulPkg::operandWidth-1:0] opB,
  input logic                               outValid,
  input logic [logMulPkg::productWidth-1:0] product
);

  // Every pair returns three cycles later
  validToResult: assert property (@(posedge clk) disable iff (!arstN)
    inValid |-> ##3 outValid)
    else $error("outValid missing three cycles after inValid");

  // No result without a pair three cycles back
  resultHasSource: assert property (@(posedge clk) disable iff (!arstN)
    outValid |-> $past(inValid, 3))
    else $error("outValid without inValid three cycles earlier");

  // Zero on either side forces zero
  zeroProduct: assert property (@(posedge clk) disable iff (!arstN)
    (inValid && (opA == '0 || opB == '0)) |-> ##3 (product == '0))
    else $error("Nonzero product for a zero operand");

endmodule

bind logMulTop logMulSva i_logMulSva (
  .clk      (clk),
  .arstN    (arstN),
  .inValid  (inValid),
  .opA      (opA),
  .opB      (opB),
  .outValid (outValid),
  .product  (product)
);

`default_nettype wire

/* testbench/logMulTb.sv */
// Log-domain multiplier testbench
// Seeded random and directed operand pairs, real-number model of the
// log and antilog rules, scoreboard queue checked at outValid

`default_nettype none

module logMulTb;
  import logMulPkg::*;

  localparam int clkPeriod = 40;
  localparam int resetCycles = 10;
  localparam int numZero = 200;
  localparam int numRandom = 2000;
  localparam int numBurst = 300;
  localparam int maxGap = 3;
  // Every test plus gaps, drains and a margin
  localparam int watchdogCycles = resetCycles + 80 + 256 + 36 + numBurst
                                  + (numZero + numRandom) * (maxGap + 1) + 500;
  localparam logic [operandWidth-1:0] extremeVals [6] = '{
    16'hFFFF, 16'h0001, 16'hFE00, 16'h007F, 16'h7F00, 16'h01FC
  };

  logic                    clk;
  logic                    arstN;
  logic                    inValid;
  logic [operandWidth-1:0] opA;
  logic [operandWidth-1:0] opB;
  logic                    outValid;
  logic [productWidth-1:0] product;

  logic [productWidth-1:0] expQ [$];
  logic [productWidth-1:0] expProduct;
  logic [2:0]              validPipe;
  int errorCount;
  int checkCount;
  int itemCount;
  int testErrors0;
  int testChecks0;
  int testItems0;

  logMulTop i_logMulTop (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .opA      (opA),
    .opB      (opB),
    .outValid (outValid),
    .product  (product)
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Position of the highest set bit
  function automatic int leadOne(input logic [operandWidth-1:0] v);
    int pos;
    pos = 0;
    for (int i = 0; i < operandWidth; i++) begin
      if (v[i]) begin
        pos = i;
      end
    end
    return pos;
  endfunction

  // Log in units of 1/64, integer part times 64 plus rounded fraction
  function automatic int operandLog(input logic [operandWidth-1:0] v);
    int  pos;
    int  m;
    int  fracInt;
    real frac;
    pos = leadOne(v);
    if (pos >= logFracWidth) begin
      m = (int'(v) >> (pos - logFracWidth)) & (tableDepth - 1);
    end else begin
      m = (int'(v) << (logFracWidth - pos)) & (tableDepth - 1);
    end
    frac = $ln(1.0 + real'(m) / real'(tableDepth)) / $ln(2.0) * real'(tableDepth);
    fracInt = $rtoi(frac + 0.5);
    if (fracInt > tableDepth - 1) begin
      fracInt = tableDepth - 1;
    end
    return pos * tableDepth + fracInt;
  endfunction

  function automatic logic [productWidth-1:0] modelProduct(
    input logic [operandWidth-1:0] a,
    input logic [operandWidth-1:0] b
  );
    int     sum;
    int     s;
    int     f;
    real    t;
    longint mant;
    longint full;
    if (a == '0 || b == '0) begin
      return '0;
    end
    sum = operandLog(a) + operandLog(b);
    s = sum / tableDepth;
    f = sum % tableDepth;
    // Octave entry, then 1.f shifted by the integer part and truncated
    t = ($pow(2.0, real'(f) / real'(tableDepth)) - 1.0) * $pow(2.0, real'(mantWidth));
    mant = (longint'(1) << mantWidth) + longint'($rtoi(t + 0.5));
    full = (mant << s) >> mantWidth;
    return full[productWidth-1:0];
  endfunction

  ////////////////////////////////////////
  // Monitor and scoreboard
  ////////////////////////////////////////

  // inValid as seen by the DUT, three cycles deep
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validPipe <= '0;
    end else begin
      validPipe <= {validPipe[1:0], inValid};
    end
  end

  // Outputs settled half a cycle after the edge
  always @(negedge clk) begin
    if (outValid !== validPipe[2]) begin
      errorCount++;
      $display("Error at %0t: outValid expected %b, got %b", $time, validPipe[2], outValid);
    end
    if (outValid === 1'b1) begin
      if (expQ.size() == 0) begin
        errorCount++;
        $display("At %0t outValid rose with no operand pair pending", $time);
      end else begin
        expProduct = expQ.pop_front();
        checkCount++;
        if (product !== expProduct) begin
          errorCount++;
          $display("Error at %0t: product expected %h, got %h", $time, expProduct, product);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic driveItem(
    input logic [operandWidth-1:0] a,
    input logic [operandWidth-1:0] b,
    input logic [productWidth-1:0] expected
  );
    @(negedge clk);
    inValid = 1'b1;
    opA = a;
    opB = b;
    expQ.push_back(expected);
    itemCount++;
  endtask

  // Idle cycles carry junk data
  task automatic idleCycles(input int n);
    repeat (n) begin
      @(negedge clk);
      inValid = 1'b0;
      opA = 16'($urandom);
      opB = 16'($urandom);
    end
  endtask

  function automatic logic [operandWidth-1:0] randomOperand();
    logic [operandWidth-1:0] raw;
    int                      shift;
    raw = 16'($urandom);
    shift = int'($urandom % operandWidth);
    return raw >> shift;
  endfunction

  task automatic beginTest();
    testErrors0 = errorCount;
    testChecks0 = checkCount;
    testItems0 = itemCount;
  endtask

  // Wait for the pipe to empty, then report
  task automatic endTest(input string name);
    idleCycles(1);
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    idleCycles(2);
    if (checkCount - testChecks0 != itemCount - testItems0) begin
      errorCount++;
      $display("Test %s sent %0d pairs but saw %0d results", name,
               itemCount - testItems0, checkCount - testChecks0);
    end
    $display("Test %s: %0d results checked, %0d errors", name,
             checkCount - testChecks0, errorCount - testErrors0);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [operandWidth-1:0] a;
    logic [operandWidth-1:0] b;
    clk = 1'b0;
    arstN = 1'b0;
    inValid = 1'b0;
    opA = '0;
    opB = '0;
    errorCount = 0;
    checkCount = 0;
    itemCount = 0;
    void'($urandom(11));
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    // Quiet after reset, then isolated items
    beginTest();
    idleCycles(20);
    repeat (8) begin
      a = randomOperand();
      b = randomOperand();
      driveItem(a, b, modelProduct(a, b));
      idleCycles(1 + int'($urandom % 5));
    end
    endTest("latency");

    // Exact powers, table entry zero
    beginTest();
    for (int i = 0; i < operandWidth; i++) begin
      for (int j = 0; j < operandWidth; j++) begin
        driveItem(16'(1) << i, 16'(1) << j, 32'(1) << (i + j));
      end
    end
    endTest("powers");

    beginTest();
    repeat (numZero) begin
      case ($urandom % 3)
        0: driveItem('0, randomOperand(), '0);
        1: driveItem(randomOperand(), '0, '0);
        default: driveItem('0, '0, '0);
      endcase
      idleCycles(int'($urandom % (maxGap + 1)));
    end
    endTest("zero");

    beginTest();
    repeat (numRandom) begin
      a = randomOperand();
      b = randomOperand();
      driveItem(a, b, modelProduct(a, b));
      idleCycles(int'($urandom % (maxGap + 1)));
    end
    endTest("random");

    // inValid held high throughout
    beginTest();
    repeat (numBurst) begin
      a = 16'($urandom);
      b = 16'($urandom);
      driveItem(a, b, modelProduct(a, b));
    end
    endTest("burst");

    beginTest();
    foreach (extremeVals[i]) begin
      foreach (extremeVals[j]) begin
        driveItem(extremeVals[i], extremeVals[j], modelProduct(extremeVals[i], extremeVals[j]));
      end
    end
    endTest("extremes");

    $display("Summary: %0d results checked, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Timeout, run still going after %0d cycles", watchdogCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
src/logMulPkg.sv
src/logOperandIf.sv
src/log2Converter.sv
src/antilogUnit.sv
src/logMulTop.sv
testbench/logMul_sva.sv
testbench/logMulTb.sv

/* Makefile */
TOOL       = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = logMulTb
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
